// File: Bender.yml
package:
  name: mt_regfile

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/rf_types_pkg.sv
      - rtl/rf_ctrl_pkg.sv
      - rtl/rf_ctrl_regs.sv
      - rtl/rf_thread_sched.sv
      - rtl/register_file.sv
      - rtl/mt_regfile_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/rf_checker.sv
      - verif/tb_mt_regfile.sv

// File: files.f
+incdir+include
rtl/rf_types_pkg.sv
rtl/rf_ctrl_pkg.sv
rtl/rf_ctrl_regs.sv
rtl/rf_thread_sched.sv
rtl/register_file.sv
rtl/mt_regfile_top.sv
verif/rf_checker.sv
verif/tb_mt_regfile.sv

// File: include/rf_defs.svh
/* sizing macros for the multithreaded register file.
   include this wherever thread, register or word counts are needed. */

`ifndef RF_DEFS_SVH
`define RF_DEFS_SVH

// hardware threads sharing the storage.
`define RF_THREADS 4

// architectural registers per thread.
`define RF_REGS 32

// width of one data word.
`define RF_XLEN 32

`endif

// File: rtl/mt_regfile_top.sv
/* top of the multithreaded register file. ties the configuration block,
   the round-robin scheduler and the storage, and tags read results. */

`timescale 1ns/10ps

module mt_regfile_top (
  input  logic                      clk,
  input  logic                      rst_n,
  // configuration port.
  input  logic                      cfg_write,
  input  rf_ctrl_pkg::cfg_reg_e     cfg_sel,
  input  rf_ctrl_pkg::thread_mask_t cfg_wdata,
  output rf_ctrl_pkg::thread_mask_t cfg_rdata,
  // read ports.
  input  rf_types_pkg::reg_addr_t   rs1_addr,
  input  rf_types_pkg::reg_addr_t   rs2_addr,
  output rf_types_pkg::word_t       rs1_data,
  output rf_types_pkg::word_t       rs2_data,
  output rf_types_pkg::thread_t     rs_thread,
  output logic                      rs_valid,
  // write port.
  input  logic                      rd_enable,
  input  rf_types_pkg::thread_t     rd_thread,
  input  rf_types_pkg::reg_addr_t   rd_addr,
  input  rf_types_pkg::word_t       rd_data
);

  rf_ctrl_pkg::thread_mask_t thread_en;
  rf_ctrl_pkg::thread_mask_t wr_protect;
  rf_types_pkg::thread_t     sched_thread;                    // thread the read ports serve now.
  logic                      sched_active;

  //////////////////////////////////////////////////////////////////////
  // blocks
  //////////////////////////////////////////////////////////////////////

  rf_ctrl_regs u_ctrl_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_write  (cfg_write),
    .cfg_sel    (cfg_sel),
    .cfg_wdata  (cfg_wdata),
    .cfg_rdata  (cfg_rdata),
    .thread_en  (thread_en),
    .wr_protect (wr_protect)
  );

  rf_thread_sched u_thread_sched (
    .clk          (clk),
    .rst_n        (rst_n),
    .thread_en    (thread_en),
    .sched_thread (sched_thread),
    .sched_active (sched_active)
  );

  register_file u_register_file (
    .clk          (clk),
    .rst_n        (rst_n),
    .rs_thread_in (sched_thread),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .rd_enable    (rd_enable),
    .rd_thread    (rd_thread),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .wr_protect   (wr_protect)
  );

  //////////////////////////////////////////////////////////////////////
  // read result tags
  //////////////////////////////////////////////////////////////////////

  // These line up with the registered read data of the storage.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rs_thread <= '0;
      rs_valid  <= 1'b0;                                      // nothing read yet.
    end else begin
      rs_thread <= sched_thread;
      rs_valid  <= sched_active;
    end
  end

endmodule

// File: rtl/register_file.sv
/* storage for all thread registers with two synchronous read ports and
   one write port. both reads use the thread given on rs_thread_in. */

`timescale 1ns/10ps

`include "rf_defs.svh"

module register_file (
  input  logic                      clk,
  input  logic                      rst_n,
  input  rf_types_pkg::thread_t     rs_thread_in,
  input  rf_types_pkg::reg_addr_t   rs1_addr,
  input  rf_types_pkg::reg_addr_t   rs2_addr,
  output rf_types_pkg::word_t       rs1_data,
  output rf_types_pkg::word_t       rs2_data,
  input  logic                      rd_enable,
  input  rf_types_pkg::thread_t     rd_thread,
  input  rf_types_pkg::reg_addr_t   rd_addr,
  input  rf_types_pkg::word_t       rd_data,
  input  rf_ctrl_pkg::thread_mask_t wr_protect
);

  rf_types_pkg::word_t       mem [`RF_THREADS*`RF_REGS];     // words of all threads by index.
  rf_types_pkg::rf_index_t   rs1_idx;
  rf_types_pkg::rf_index_t   rs2_idx;
  rf_types_pkg::rf_index_t   wr_idx;
  logic                      wr_en;                           // write strobe after protection.

  assign rs1_idx = {rs1_addr, rs_thread_in};
  assign rs2_idx = {rs2_addr, rs_thread_in};
  assign wr_idx  = {rd_addr, rd_thread};
  assign wr_en   = rd_enable && !wr_protect[rd_thread];

  //////////////////////////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////////////////////////

  // The array is cleared so every register of every thread reads as zero
  // straight out of reset.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `RF_THREADS*`RF_REGS; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[wr_idx] <= rd_data;                                 // x0 is stored like any other register.
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read ports
  //////////////////////////////////////////////////////////////////////

  // Reads sample the array before this edge's write, so a same-cycle
  // write to the same register is seen one read later.
  always_ff @(posedge clk) begin
    rs1_data <= (rs1_addr == '0) ? '0 : mem[rs1_idx];         // x0 always reads zero.
    rs2_data <= (rs2_addr == '0) ? '0 : mem[rs2_idx];
  end

  //////////////////////////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////////////////////////

  // an unprotected write comes back on a read of that index one edge later.
  a_rs1_read: assert property (
    @(posedge clk) disable iff (!rst_n)
      $past(wr_en) && ($past(rd_addr) != '0) && (rs1_idx == $past(wr_idx))
        |=> rs1_data == $past(rd_data, 2)
  ) else $error("rs1 missed the word written to index %0h", $past(wr_idx, 2));

  a_rs2_read: assert property (
    @(posedge clk) disable iff (!rst_n)
      $past(wr_en) && ($past(rd_addr) != '0) && (rs2_idx == $past(wr_idx))
        |=> rs2_data == $past(rd_data, 2)
  ) else $error("rs2 missed the word written to index %0h", $past(wr_idx, 2));

  // both ports on one nonzero register agree a cycle later.
  a_ports_agree: assert property (
    @(posedge clk) disable iff (!rst_n)
      (rs1_addr == rs2_addr) && (rs1_addr != '0) |=> rs1_data == rs2_data
  ) else $error("read ports disagree on the same register");

endmodule

// File: rtl/rf_ctrl_pkg.sv
/* control side types: the per-thread mask and the select that picks
   one of the configuration registers for write and readback. */

package rf_ctrl_pkg;

  `include "rf_defs.svh"

  //////////////////////////////////////////////////////////////////////
  // configuration registers
  //////////////////////////////////////////////////////////////////////

  typedef logic [`RF_THREADS-1:0] thread_mask_t;              // one bit per thread.

  typedef enum logic [0:0] {
    REG_THREAD_EN  = 1'b0,                                    // threads taking part in scheduling.
    REG_WR_PROTECT = 1'b1                                     // threads whose writes are dropped.
  } cfg_reg_e;

endpackage

// File: rtl/rf_ctrl_regs.sv
/* configuration register block holding the thread enable and write
   protect masks, written by single-cycle strobes and read back live. */

`timescale 1ns/10ps

module rf_ctrl_regs (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      cfg_write,
  input  rf_ctrl_pkg::cfg_reg_e     cfg_sel,
  input  rf_ctrl_pkg::thread_mask_t cfg_wdata,
  output rf_ctrl_pkg::thread_mask_t cfg_rdata,
  output rf_ctrl_pkg::thread_mask_t thread_en,
  output rf_ctrl_pkg::thread_mask_t wr_protect
);

  //////////////////////////////////////////////////////////////////////
  // mask registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      thread_en  <= '1;                                       // every thread runs out of reset.
      wr_protect <= '0;                                       // and every thread may write.
    end else if (cfg_write) begin
      case (cfg_sel)
        rf_ctrl_pkg::REG_THREAD_EN:  thread_en  <= cfg_wdata;
        rf_ctrl_pkg::REG_WR_PROTECT: wr_protect <= cfg_wdata;
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // readback
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (cfg_sel)
      rf_ctrl_pkg::REG_THREAD_EN:  cfg_rdata = thread_en;
      rf_ctrl_pkg::REG_WR_PROTECT: cfg_rdata = wr_protect;
      default:                     cfg_rdata = '0;           // unreachable with a 1-bit select.
    endcase
  end

  // an unknown select on a write strobe would leave both masks undefined
  // on the following cycle.
  a_cfg_sel_known: assert property (
    @(posedge clk) disable iff (!rst_n)
      cfg_write |-> !$isunknown(cfg_sel)
  ) else $error("cfg_sel unknown during configuration write");

endmodule

// File: rtl/rf_thread_sched.sv
/* round-robin thread selector for the read ports. advances one step per
   cycle through the enabled threads, counting upward and wrapping. */

`timescale 1ns/10ps

`include "rf_defs.svh"

module rf_thread_sched (
  input  logic                      clk,
  input  logic                      rst_n,
  input  rf_ctrl_pkg::thread_mask_t thread_en,
  output rf_types_pkg::thread_t     sched_thread,
  output logic                      sched_active
);

  rf_types_pkg::thread_t next_thread;                         // next enabled thread after this one.
  logic                  any_enabled;                         // at least one thread may run.

  assign any_enabled = |thread_en;

  //////////////////////////////////////////////////////////////////////
  // next thread search
  //////////////////////////////////////////////////////////////////////

  // The search starts one past the current thread and ends on the current
  // thread itself, so a single enabled thread keeps being picked.
  always_comb begin
    int unsigned cand;
    logic        found;
    cand        = 0;
    found       = 1'b0;
    next_thread = sched_thread;                               // hold when nothing is enabled.
    for (int i = 1; i <= `RF_THREADS; i++) begin
      cand = (int'(sched_thread) + i) % `RF_THREADS;
      if (!found && thread_en[cand]) begin
        next_thread = rf_types_pkg::thread_t'(cand);
        found       = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // thread pointer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sched_thread <= rf_types_pkg::thread_t'(`RF_THREADS - 1); // so thread 0 comes first.
      sched_active <= 1'b1;
    end else begin
      if (any_enabled) begin
        sched_thread <= next_thread;
      end
      sched_active <= any_enabled;                            // low while the mask is empty.
    end
  end

  // a step taken under a nonempty mask must land on a thread of that mask.
  a_sched_enabled: assert property (
    @(posedge clk) disable iff (!rst_n)
      sched_active && any_enabled |=> !$stable(thread_en) || thread_en[sched_thread]
  ) else $error("scheduler picked disabled thread %0d", sched_thread);

endmodule

// File: rtl/rf_types_pkg.sv
/* datapath types for the register file: words, register numbers,
   thread ids and the flat storage index built from them. */

package rf_types_pkg;

  `include "rf_defs.svh"

  //////////////////////////////////////////////////////////////////////
  // datapath vectors
  //////////////////////////////////////////////////////////////////////

  typedef logic [`RF_XLEN-1:0] word_t;                        // one data word.
  typedef logic [$clog2(`RF_REGS)-1:0] reg_addr_t;            // register number.
  typedef logic [$clog2(`RF_THREADS)-1:0] thread_t;           // hardware thread id.

  // storage index with the register number on top and the thread id below.
  typedef logic [$bits(reg_addr_t)+$bits(thread_t)-1:0] rf_index_t;

endpackage

// File: verif/rf_checker.sv
/* checker for the register file testbench. compares the DUT read results and
   config readback with the reference predictions on every rising edge. */

`timescale 1ns/10ps

module rf_checker (
  input  logic                      clk,
  input  logic                      rst_n,
  input  int                        test_id,
  input  logic                      rs_valid,
  input  rf_types_pkg::thread_t     rs_thread,
  input  rf_types_pkg::word_t       rs1_data,
  input  rf_types_pkg::word_t       rs2_data,
  input  rf_ctrl_pkg::thread_mask_t cfg_rdata,
  input  logic                      exp_valid,
  input  rf_types_pkg::thread_t     exp_thread,
  input  rf_types_pkg::word_t       exp_rs1,
  input  rf_types_pkg::word_t       exp_rs2,
  input  rf_ctrl_pkg::thread_mask_t exp_cfg,
  output int                        error_count,
  output int                        check_count
);

  int valid_errors = 0;                                       // rs_valid off the prediction.
  int data_errors  = 0;                                       // thread tag or read word wrong.
  int cfg_errors   = 0;
  int reads        = 0;

  assign error_count = valid_errors + data_errors + cfg_errors;
  assign check_count = reads;

  function automatic string test_label(int id);
    case (id)
      1:       return "reset_zero";
      2:       return "random_write_read";
      3:       return "same_cycle_write_read";
      4:       return "write_protect";
      5:       return "thread_enable";
      default: return "idle";
    endcase
  endfunction

  function automatic void mismatch(string field, logic [31:0] expected, logic [31:0] actual);
    $display("CHECK FAILED %s %s: expected %0h, actual %0h at %0t",
             test_label(test_id), field, expected, actual, $time);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // comparison
  //////////////////////////////////////////////////////////////////////

  // Outputs and predictions both change only through nonblocking updates,
  // so at the edge they still hold the previous cycle's values.
  always @(posedge clk) begin
    if (rst_n) begin
      if (rs_valid !== exp_valid) begin
        mismatch("rs_valid", exp_valid, rs_valid);
        valid_errors++;
      end else if (exp_valid) begin
        reads++;
        if (rs_thread !== exp_thread) begin
          mismatch("rs_thread", exp_thread, rs_thread);
          data_errors++;
        end
        if (rs1_data !== exp_rs1) begin
          mismatch("rs1_data", exp_rs1, rs1_data);
          data_errors++;
        end
        if (rs2_data !== exp_rs2) begin
          mismatch("rs2_data", exp_rs2, rs2_data);
          data_errors++;
        end
      end
      if (cfg_rdata !== exp_cfg) begin
        mismatch("cfg_rdata", exp_cfg, cfg_rdata);             // readback of the selected mask.
        cfg_errors++;
      end
    end
  end

  task automatic print_summary(int timeouts);
    $display("errors: %0d valid, %0d data, %0d config, %0d timeouts; %0d reads compared",
             valid_errors, data_errors, cfg_errors, timeouts, reads);
  endtask

endmodule

// File: verif/tb_mt_regfile.sv
/* testbench for the multithreaded register file. drives the DUT on falling
   edges and keeps a reference model whose predictions rf_checker compares. */

`timescale 1ns/10ps

`include "rf_defs.svh"

module tb_mt_regfile;

  logic                      clk;
  logic                      rst_n;
  logic                      cfg_write;
  rf_ctrl_pkg::cfg_reg_e     cfg_sel;
  rf_ctrl_pkg::thread_mask_t cfg_wdata;
  rf_ctrl_pkg::thread_mask_t cfg_rdata;
  rf_types_pkg::reg_addr_t   rs1_addr;
  rf_types_pkg::reg_addr_t   rs2_addr;
  rf_types_pkg::word_t       rs1_data;
  rf_types_pkg::word_t       rs2_data;
  rf_types_pkg::thread_t     rs_thread;
  logic                      rs_valid;
  logic                      rd_enable;
  rf_types_pkg::thread_t     rd_thread;
  rf_types_pkg::reg_addr_t   rd_addr;
  rf_types_pkg::word_t       rd_data;

  rf_types_pkg::word_t       ref_mem [`RF_THREADS][`RF_REGS]; // model of the storage.
  rf_ctrl_pkg::thread_mask_t ref_en;
  rf_ctrl_pkg::thread_mask_t ref_prot;
  rf_types_pkg::thread_t     ref_sched;                       // thread the reads use this cycle.
  logic                      ref_active;
  logic                      exp_valid;
  rf_types_pkg::thread_t     exp_thread;
  rf_types_pkg::word_t       exp_rs1;
  rf_types_pkg::word_t       exp_rs2;
  rf_ctrl_pkg::thread_mask_t exp_cfg;
  int                        test_id;
  int                        timeouts;
  int                        check_errors;
  int                        check_count;
  rf_ctrl_pkg::thread_mask_t narrow_masks [4] = '{4'b0001, 4'b0100, 4'b1010, 4'b0110};

  mt_regfile_top DUT (.*);

  rf_checker u_checker (
    .clk (clk), .rst_n (rst_n), .test_id (test_id), .rs_valid (rs_valid),
    .rs_thread (rs_thread), .rs1_data (rs1_data), .rs2_data (rs2_data),
    .cfg_rdata (cfg_rdata), .exp_valid (exp_valid), .exp_thread (exp_thread),
    .exp_rs1 (exp_rs1), .exp_rs2 (exp_rs2), .exp_cfg (exp_cfg),
    .error_count (check_errors), .check_count (check_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // picks the next enabled thread above cur with wraparound and keeps cur when it is alone.
  function automatic rf_types_pkg::thread_t next_enabled(rf_types_pkg::thread_t cur,
                                                         rf_ctrl_pkg::thread_mask_t mask);
    rf_types_pkg::thread_t t;
    t = cur;
    repeat (`RF_THREADS) begin
      t = t + 1'b1;                                           // wraps at the thread count.
      if (mask[t]) begin
        return t;
      end
    end
    return cur;
  endfunction

  function automatic rf_types_pkg::word_t stored_word(rf_types_pkg::thread_t t,
                                                      rf_types_pkg::reg_addr_t a);
    return (a == '0) ? '0 : ref_mem[t][a];                    // x0 reads zero whatever was written.
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int t = 0; t < `RF_THREADS; t++) begin
        for (int r = 0; r < `RF_REGS; r++) begin
          ref_mem[t][r] <= '0;
        end
      end
      ref_en     <= '1;
      ref_prot   <= '0;
      ref_sched  <= rf_types_pkg::thread_t'(`RF_THREADS - 1);
      ref_active <= 1'b1;
      exp_valid  <= 1'b0;
      exp_thread <= '0;
      exp_rs1    <= '0;
      exp_rs2    <= '0;
    end else begin
      exp_valid  <= ref_active;
      exp_thread <= ref_sched;
      exp_rs1    <= stored_word(ref_sched, rs1_addr);         // old word on a same-cycle write.
      exp_rs2    <= stored_word(ref_sched, rs2_addr);
      ref_active <= |ref_en;
      if (|ref_en) begin
        ref_sched <= next_enabled(ref_sched, ref_en);
      end
      if (rd_enable && !ref_prot[rd_thread]) begin
        ref_mem[rd_thread][rd_addr] <= rd_data;
      end
      if (cfg_write && cfg_sel == rf_ctrl_pkg::REG_THREAD_EN) begin
        ref_en <= cfg_wdata;
      end else if (cfg_write) begin
        ref_prot <= cfg_wdata;
      end
    end
  end

  assign exp_cfg = (cfg_sel == rf_ctrl_pkg::REG_THREAD_EN) ? ref_en : ref_prot;

  //////////////////////////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic drive_cycle(logic wr, rf_types_pkg::thread_t wt, rf_types_pkg::reg_addr_t wa,
                             rf_types_pkg::word_t wd, rf_types_pkg::reg_addr_t ra1,
                             rf_types_pkg::reg_addr_t ra2);
    @(negedge clk);
    cfg_write = 1'b0;
    rd_enable = wr;
    rd_thread = wt;
    rd_addr   = wa;
    rd_data   = wd;
    rs1_addr  = ra1;
    rs2_addr  = ra2;
  endtask

  task automatic random_traffic(int cycles);
    for (int i = 0; i < cycles; i++) begin
      drive_cycle($urandom_range(3) != 0, rf_types_pkg::thread_t'($urandom()),
                  rf_types_pkg::reg_addr_t'($urandom()), rf_types_pkg::word_t'($urandom()),
                  rf_types_pkg::reg_addr_t'($urandom()), rf_types_pkg::reg_addr_t'($urandom()));
    end
  endtask

  // each register is held for one full rotation so every thread reads it.
  task automatic read_sweep();
    for (int i = 0; i < `RF_THREADS * `RF_REGS; i++) begin
      drive_cycle(1'b0, '0, '0, '0, rf_types_pkg::reg_addr_t'(i / `RF_THREADS),
                  rf_types_pkg::reg_addr_t'(i / `RF_THREADS + 1));
    end
  endtask

  task automatic write_while_read(rf_types_pkg::reg_addr_t addr, rf_types_pkg::word_t value);
    @(negedge clk);
    cfg_write = 1'b0;
    rd_enable = 1'b1;
    rd_thread = ref_sched;                                    // the thread read at the next edge.
    rd_addr   = addr;
    rd_data   = value;
    rs1_addr  = addr;
    rs2_addr  = addr;
  endtask

  task automatic cfg_store(rf_ctrl_pkg::cfg_reg_e sel, rf_ctrl_pkg::thread_mask_t value);
    @(negedge clk);
    rd_enable = 1'b0;
    cfg_write = 1'b1;
    cfg_sel   = sel;
    cfg_wdata = value;
    @(negedge clk);
    cfg_write = 1'b0;
  endtask

  task automatic wait_for_valid(logic level, int limit);
    int n;
    n = 0;
    while (rs_valid !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (rs_valid !== level) begin
      $display("timeout: rs_valid did not reach %0b within %0d cycles", level, limit);
      timeouts++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(5));
    rst_n     = 1'b0;
    cfg_write = 1'b0;
    cfg_sel   = rf_ctrl_pkg::REG_THREAD_EN;
    cfg_wdata = '0;
    rs1_addr  = '0;
    rs2_addr  = '0;
    rd_enable = 1'b0;
    rd_thread = '0;
    rd_addr   = '0;
    rd_data   = '0;
    test_id   = 0;
    timeouts  = 0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    test_id = 1;
    read_sweep();

    test_id = 2;
    random_traffic(300);
    read_sweep();

    test_id = 3;
    for (int i = 1; i < 9; i++) begin
      write_while_read(rf_types_pkg::reg_addr_t'(i * 3), rf_types_pkg::word_t'($urandom()));
      repeat (`RF_THREADS + 1) begin
        drive_cycle(1'b0, '0, '0, '0, rf_types_pkg::reg_addr_t'(i * 3),
                    rf_types_pkg::reg_addr_t'(i * 3));
      end
    end

    test_id = 4;
    cfg_store(rf_ctrl_pkg::REG_WR_PROTECT, 4'b0010);
    cfg_store(rf_ctrl_pkg::REG_THREAD_EN, 4'b1111);           // readback both masks.
    random_traffic(200);
    read_sweep();
    cfg_store(rf_ctrl_pkg::REG_WR_PROTECT, '0);

    test_id = 5;
    foreach (narrow_masks[m]) begin
      cfg_store(rf_ctrl_pkg::REG_THREAD_EN, narrow_masks[m]);
      random_traffic(12);
    end
    cfg_store(rf_ctrl_pkg::REG_THREAD_EN, '0);
    wait_for_valid(1'b0, 8);
    random_traffic(4);
    cfg_store(rf_ctrl_pkg::REG_THREAD_EN, '1);
    wait_for_valid(1'b1, 8);
    random_traffic(8);
    drive_cycle(1'b0, '0, '0, '0, '0, '0);
    drive_cycle(1'b0, '0, '0, '0, '0, '0);

    test_id = 0;
    u_checker.print_summary(timeouts);
    if (check_errors == 0 && timeouts == 0 && check_count > 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
